// ==== csr_params.svh ====
// data and index widths, csr write masks
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// datapath
`define XLEN        32  // rv32 data width
`define CSR_ADDR_W  12  // csr address field
`define REG_ADDR_W  5   // gpr index
`define COMMIT_ID_W 3   // commit id tag

// mstatus only keeps mie (bit 3) and mpie (bit 7)
`define MSTATUS_WMASK 32'h0000_0088

// mtvec and mepc keep word alignment
`define TVEC_EPC_WMASK 32'hffff_fffc

`endif

// ==== csr_pkg.sv ====
// csr operation enum, csr address type and csr address enum
`include "csr_params.svh"

package csr_pkg;

    // encodings follow funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,  // csrrw / csrrwi
        CSR_RS = 2'b10,  // csrrs / csrrsi
        CSR_RC = 2'b11   // csrrc / csrrci
    } csr_op_e;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // implemented machine csrs
    typedef enum csr_addr_t {
        CSR_MSTATUS  = 12'h300,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342
    } csr_addr_e;

endpackage

// ==== csr_decode.sv ====
// csr_decode: csr instruction decode, csr read, same-address hazard stall
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_decode (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // upstream issue handshake
    input  logic                    instr_valid_i,
    input  logic [31:0]             instr_i,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`COMMIT_ID_W-1:0] commit_id_i,
    output logic                    instr_ready_o,

    // csr read port
    output csr_pkg::csr_addr_t      csr_raddr_o,
    input  logic [`XLEN-1:0]        csr_rdata_i,

    // write held in the execute stage
    input  logic                    pend_we_i,
    input  csr_pkg::csr_addr_t      pend_addr_i,

    // to execute unit
    output logic                    dec_valid_o,
    output csr_pkg::csr_op_e        dec_op_o,
    output logic [`XLEN-1:0]        dec_operand_o,
    output logic [`XLEN-1:0]        dec_old_value_o,
    output csr_pkg::csr_addr_t      dec_csr_addr_o,
    output logic                    dec_csr_we_o,
    output logic [`REG_ADDR_W-1:0]  dec_rd_addr_o,
    output logic [`COMMIT_ID_W-1:0] dec_commit_id_o,
    input  logic                    dec_ready_i
);

    // instruction fields
    logic [2:0]            funct3;
    logic [4:0]            src;      // rs1 index or uimm
    logic                  use_imm;  // funct3[2] selects immediate form
    csr_pkg::csr_addr_t    csr_addr;
    logic                  hazard;

    assign funct3   = instr_i[14:12];
    assign src      = instr_i[19:15];
    assign use_imm  = funct3[2];
    assign csr_addr = instr_i[31:20];

    // operation from funct3[1:0]
    always_comb begin
        case (funct3[1:0])
            2'b10:   dec_op_o = csr_pkg::CSR_RS;
            2'b11:   dec_op_o = csr_pkg::CSR_RC;
            default: dec_op_o = csr_pkg::CSR_RW;
        endcase
    end

    // zero-extended uimm or rs1 value
    assign dec_operand_o = use_imm ? {{(`XLEN-5){1'b0}}, src} : rs1_data_i;

    // set/clear with zero source never writes
    assign dec_csr_we_o = (dec_op_o == csr_pkg::CSR_RW) | (src != 5'd0);

    // old value straight from the register file
    assign csr_raddr_o     = csr_addr;
    assign dec_old_value_o = csr_rdata_i;

    // read after a write still sitting in execute would see a stale value
    assign hazard = pend_we_i && (pend_addr_i == csr_addr);

    assign dec_valid_o   = instr_valid_i & ~hazard;
    assign instr_ready_o = dec_ready_i & ~hazard;

    // pass-through payload
    assign dec_csr_addr_o  = csr_addr;
    assign dec_rd_addr_o   = instr_i[11:7];
    assign dec_commit_id_o = commit_id_i;

endmodule

// ==== csr_exec_unit.sv ====
// csr_exec_unit: new csr value and rd result, interrupt flush, output register stage
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_exec_unit (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // from decoder
    input  logic                    dec_valid_i,
    input  csr_pkg::csr_op_e        dec_op_i,
    input  logic [`XLEN-1:0]        dec_operand_i,
    input  logic [`XLEN-1:0]        dec_old_value_i,
    input  csr_pkg::csr_addr_t      dec_csr_addr_i,
    input  logic                    dec_csr_we_i,
    input  logic [`REG_ADDR_W-1:0]  dec_rd_addr_i,
    input  logic [`COMMIT_ID_W-1:0] dec_commit_id_i,
    output logic                    dec_ready_o,

    input  logic                    int_assert_i,  // flush request

    // held result
    output logic                    ex_valid_o,
    output logic                    ex_csr_we_o,
    output csr_pkg::csr_addr_t      ex_csr_addr_o,
    output logic [`XLEN-1:0]        ex_csr_wdata_o,
    output logic [`REG_ADDR_W-1:0]  ex_rd_addr_o,
    output logic [`XLEN-1:0]        ex_rd_data_o,
    output logic [`COMMIT_ID_W-1:0] ex_commit_id_o,
    input  logic                    wb_ready_i
);

    logic [`XLEN-1:0] csr_wdata_nxt;
    logic             load;   // stage may take new contents
    logic             take;   // decoder transfer this edge

    // control state
    logic             valid_q;
    logic             csr_we_q;

    // payload, no reset
    csr_pkg::csr_addr_t      csr_addr_q;
    logic [`XLEN-1:0]        csr_wdata_q;
    logic [`REG_ADDR_W-1:0]  rd_addr_q;
    logic [`XLEN-1:0]        rd_data_q;
    logic [`COMMIT_ID_W-1:0] commit_id_q;

    // write / set / clear
    always_comb begin
        case (dec_op_i)
            csr_pkg::CSR_RS: csr_wdata_nxt = dec_old_value_i | dec_operand_i;
            csr_pkg::CSR_RC: csr_wdata_nxt = dec_old_value_i & ~dec_operand_i;
            default:         csr_wdata_nxt = dec_operand_i;
        endcase
    end

    assign load        = ~valid_q | wb_ready_i;  // empty or leaving
    assign take        = dec_valid_i & load;
    assign dec_ready_o = load;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q  <= 1'b0;
            csr_we_q <= 1'b0;
        end else if (load) begin
            valid_q  <= dec_valid_i & ~int_assert_i;  // interrupt loads a bubble
            csr_we_q <= dec_valid_i & ~int_assert_i & dec_csr_we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            csr_addr_q  <= dec_csr_addr_i;
            csr_wdata_q <= csr_wdata_nxt;
            rd_addr_q   <= dec_rd_addr_i;
            rd_data_q   <= dec_old_value_i;  // rd gets the old csr value
            commit_id_q <= dec_commit_id_i;
        end
    end

    assign ex_valid_o     = valid_q;
    assign ex_csr_we_o    = csr_we_q;
    assign ex_csr_addr_o  = csr_addr_q;
    assign ex_csr_wdata_o = csr_wdata_q;
    assign ex_rd_addr_o   = rd_addr_q;
    assign ex_rd_data_o   = rd_data_q;
    assign ex_commit_id_o = commit_id_q;

endmodule

// ==== csr_regfile.sv ====
// csr_regfile: five machine csrs, masked commit, csr read port, write-back outputs
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_regfile (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // read port for the decoder
    input  csr_pkg::csr_addr_t      csr_raddr_i,
    output logic [`XLEN-1:0]        csr_rdata_o,

    // result held in execute
    input  logic                    ex_valid_i,
    input  logic                    ex_csr_we_i,
    input  csr_pkg::csr_addr_t      ex_csr_addr_i,
    input  logic [`XLEN-1:0]        ex_csr_wdata_i,
    input  logic [`REG_ADDR_W-1:0]  ex_rd_addr_i,
    input  logic [`XLEN-1:0]        ex_rd_data_i,
    input  logic [`COMMIT_ID_W-1:0] ex_commit_id_i,

    // write-back handshake
    input  logic                    wb_ready_i,
    output logic                    wb_valid_o,
    output logic                    rd_we_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic [`XLEN-1:0]        rd_data_o,
    output logic [`COMMIT_ID_W-1:0] commit_id_o
);

    logic [`XLEN-1:0] mstatus_q;
    logic [`XLEN-1:0] mtvec_q;
    logic [`XLEN-1:0] mscratch_q;
    logic [`XLEN-1:0] mepc_q;
    logic [`XLEN-1:0] mcause_q;
    logic             commit;

    // csr write lands with the write-back transfer
    assign commit = ex_valid_i & wb_ready_i & ex_csr_we_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else if (commit) begin
            case (ex_csr_addr_i)
                csr_pkg::CSR_MSTATUS:  mstatus_q  <= ex_csr_wdata_i & `MSTATUS_WMASK;
                csr_pkg::CSR_MTVEC:    mtvec_q    <= ex_csr_wdata_i & `TVEC_EPC_WMASK;
                csr_pkg::CSR_MSCRATCH: mscratch_q <= ex_csr_wdata_i;
                csr_pkg::CSR_MEPC:     mepc_q     <= ex_csr_wdata_i & `TVEC_EPC_WMASK;
                csr_pkg::CSR_MCAUSE:   mcause_q   <= ex_csr_wdata_i;
                default: ;  // unimplemented, write dropped
            endcase
        end
    end

    // combinational read
    always_comb begin
        case (csr_raddr_i)
            csr_pkg::CSR_MSTATUS:  csr_rdata_o = mstatus_q;
            csr_pkg::CSR_MTVEC:    csr_rdata_o = mtvec_q;
            csr_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            csr_pkg::CSR_MEPC:     csr_rdata_o = mepc_q;
            csr_pkg::CSR_MCAUSE:   csr_rdata_o = mcause_q;
            default:               csr_rdata_o = '0;  // unknown reads zero
        endcase
    end

    // outward write-back
    assign wb_valid_o  = ex_valid_i;
    assign rd_we_o     = ex_valid_i & (ex_rd_addr_i != '0);  // x0 never written
    assign rd_addr_o   = ex_rd_addr_i;
    assign rd_data_o   = ex_rd_data_i;
    assign commit_id_o = ex_commit_id_i;

endmodule

// ==== csr_top.sv ====
// csr_top: decoder, execute unit and csr register file
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_top (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // issue side
    input  logic                    instr_valid_i,
    output logic                    instr_ready_o,
    input  logic [31:0]             instr_i,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`COMMIT_ID_W-1:0] commit_id_i,
    input  logic                    int_assert_i,

    // write-back side
    output logic                    wb_valid_o,
    input  logic                    wb_ready_i,
    output logic                    rd_we_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic [`XLEN-1:0]        rd_data_o,
    output logic [`COMMIT_ID_W-1:0] commit_id_o
);

    // decode -> execute
    logic                    dec_valid;
    logic                    dec_ready;
    csr_pkg::csr_op_e        dec_op;
    logic [`XLEN-1:0]        dec_operand;
    logic [`XLEN-1:0]        dec_old_value;
    csr_pkg::csr_addr_t      dec_csr_addr;
    logic                    dec_csr_we;
    logic [`REG_ADDR_W-1:0]  dec_rd_addr;
    logic [`COMMIT_ID_W-1:0] dec_commit_id;

    // csr read port
    csr_pkg::csr_addr_t      csr_raddr;
    logic [`XLEN-1:0]        csr_rdata;

    // execute -> regfile, also the pending write seen by decode
    logic                    ex_valid;
    logic                    ex_csr_we;
    csr_pkg::csr_addr_t      ex_csr_addr;
    logic [`XLEN-1:0]        ex_csr_wdata;
    logic [`REG_ADDR_W-1:0]  ex_rd_addr;
    logic [`XLEN-1:0]        ex_rd_data;
    logic [`COMMIT_ID_W-1:0] ex_commit_id;

    csr_decode csr_decode_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_valid_i(instr_valid_i), .instr_i(instr_i), .rs1_data_i(rs1_data_i),
        .commit_id_i(commit_id_i), .instr_ready_o(instr_ready_o),
        .csr_raddr_o(csr_raddr), .csr_rdata_i(csr_rdata),
        .pend_we_i(ex_csr_we), .pend_addr_i(ex_csr_addr),
        .dec_valid_o(dec_valid), .dec_op_o(dec_op), .dec_operand_o(dec_operand),
        .dec_old_value_o(dec_old_value), .dec_csr_addr_o(dec_csr_addr),
        .dec_csr_we_o(dec_csr_we), .dec_rd_addr_o(dec_rd_addr),
        .dec_commit_id_o(dec_commit_id), .dec_ready_i(dec_ready)
    );

    csr_exec_unit csr_exec_unit_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .dec_valid_i(dec_valid), .dec_op_i(dec_op), .dec_operand_i(dec_operand),
        .dec_old_value_i(dec_old_value), .dec_csr_addr_i(dec_csr_addr),
        .dec_csr_we_i(dec_csr_we), .dec_rd_addr_i(dec_rd_addr),
        .dec_commit_id_i(dec_commit_id), .dec_ready_o(dec_ready),
        .int_assert_i(int_assert_i),
        .ex_valid_o(ex_valid), .ex_csr_we_o(ex_csr_we), .ex_csr_addr_o(ex_csr_addr),
        .ex_csr_wdata_o(ex_csr_wdata), .ex_rd_addr_o(ex_rd_addr),
        .ex_rd_data_o(ex_rd_data), .ex_commit_id_o(ex_commit_id), .wb_ready_i(wb_ready_i)
    );

    csr_regfile csr_regfile_inst (
        .clk(clk), .rst_n_i(rst_n_i),
        .csr_raddr_i(csr_raddr), .csr_rdata_o(csr_rdata),
        .ex_valid_i(ex_valid), .ex_csr_we_i(ex_csr_we), .ex_csr_addr_i(ex_csr_addr),
        .ex_csr_wdata_i(ex_csr_wdata), .ex_rd_addr_i(ex_rd_addr),
        .ex_rd_data_i(ex_rd_data), .ex_commit_id_i(ex_commit_id), .wb_ready_i(wb_ready_i),
        .wb_valid_o(wb_valid_o), .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o),
        .rd_data_o(rd_data_o), .commit_id_o(commit_id_o)
    );

endmodule

// ==== csr_tb.sv ====
// csr_tb: clock, reset, stimulus table, reference csr model, write-back monitor, timeout
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_tb;

    typedef struct {
        csr_pkg::csr_op_e op;
        logic             imm;   // immediate form
        logic [4:0]       src;   // rs1 index or uimm
        logic [31:0]      rs1;
        logic [11:0]      addr;
        logic [4:0]       rd;
        logic             intr;  // interrupt in the accept cycle
        logic             rnd;   // random wb_ready_i while this row runs
    } row_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [2:0]  cid;
        logic [31:0] data;
    } wb_t;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    instr_valid_i;
    logic                    instr_ready_o;
    logic [31:0]             instr_i;
    logic [`XLEN-1:0]        rs1_data_i;
    logic [`COMMIT_ID_W-1:0] commit_id_i;
    logic                    int_assert_i;
    logic                    wb_valid_o;
    logic                    wb_ready_i;
    logic                    rd_we_o;
    logic [`REG_ADDR_W-1:0]  rd_addr_o;
    logic [`XLEN-1:0]        rd_data_o;
    logic [`COMMIT_ID_W-1:0] commit_id_o;

    row_t        rows[$];
    wb_t         exp_q[$];              // results in issue order
    logic [31:0] ref_csr [0:4095];      // whole csr space, unknown ones stay zero
    int          seed = 32'hd5ac_713c;
    int          cycles = 0;
    int          limit = 1000;

    csr_top csr_top_inst (.*);

    always #20 clk = ~clk;  // 40 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            fail_run($sformatf("ERR @%0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic add_row(input csr_pkg::csr_op_e op, input logic imm, input logic [4:0] src,
                           input logic [31:0] rs1, input logic [11:0] addr,
                           input logic [4:0] rd, input logic intr, input logic rnd);
        rows.push_back('{op, imm, src, rs1, addr, rd, intr, rnd});
    endtask

    // writable bits per address
    function automatic logic [31:0] wmask(input logic [11:0] a);
        case (a)
            csr_pkg::CSR_MSTATUS:                 wmask = 32'h0000_0088;  // mie, mpie
            csr_pkg::CSR_MTVEC, csr_pkg::CSR_MEPC: wmask = 32'hffff_fffc;  // word aligned
            csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MCAUSE: wmask = 32'hffff_ffff;
            default:                              wmask = 32'h0;
        endcase
    endfunction

    // old value to rd, new value into the model unless flushed
    task automatic predict(input row_t r, input logic [2:0] cid);
        logic [31:0] old;
        logic [31:0] opnd;
        logic [31:0] nv;
        old  = ref_csr[r.addr];
        opnd = r.imm ? {27'd0, r.src} : r.rs1;
        case (r.op)
            csr_pkg::CSR_RW: nv = opnd;
            csr_pkg::CSR_RS: nv = old | opnd;
            default:         nv = old & ~opnd;
        endcase
        if (!r.intr) begin
            if (r.op == csr_pkg::CSR_RW || r.src != 5'd0)  // zero source never writes
                ref_csr[r.addr] = nv & wmask(r.addr);
            exp_q.push_back('{(r.rd != 5'd0), r.rd, cid, old});
        end
    endtask

    // next cycle, inputs change 1 ns after the edge
    task automatic step_cycle(input logic rnd);
        int r;
        @(posedge clk);
        #1;
        r = $random(seed);
        wb_ready_i = rnd ? r[0] : 1'b1;
    endtask

    // write-back monitor, sampled mid-cycle
    always @(negedge clk) begin
        wb_t e;
        if (rst_n_i && wb_valid_o && wb_ready_i) begin
            if (exp_q.size() == 0) begin
                fail_run("a write-back came out with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value(commit_id_o, e.cid, "commit_id_o");
                check_value(rd_we_o, e.we, "rd_we_o");
                check_value(rd_addr_o, e.rd, "rd_addr_o");
                check_value(rd_data_o, e.data, "rd_data_o");
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            fail_run($sformatf("timeout: %0d write-back results still missing after %0d cycles",
                               exp_q.size(), cycles));
    end

    initial begin
        row_t       r;
        logic       accepted;
        logic [1:0] f3;
        logic [2:0] cid;
        cid           = '0;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        commit_id_i   = '0;
        int_assert_i  = 1'b0;
        wb_ready_i    = 1'b1;
        for (int a = 0; a < 4096; a++)
            ref_csr[a] = '0;
        //      op               imm src    rs1           addr     rd  int rnd
        add_row(csr_pkg::CSR_RW, 0, 5'd1,  32'hdead_beef, 12'h340, 5,  0, 0);
        add_row(csr_pkg::CSR_RS, 0, 5'd2,  32'h0000_00f0, 12'h340, 6,  0, 0);
        add_row(csr_pkg::CSR_RC, 1, 5'h0f, 32'h0,         12'h340, 7,  0, 0);
        add_row(csr_pkg::CSR_RW, 1, 5'h15, 32'h0,         12'h342, 8,  0, 0);
        add_row(csr_pkg::CSR_RS, 1, 5'h0a, 32'h0,         12'h342, 9,  0, 0);
        add_row(csr_pkg::CSR_RC, 0, 5'd3,  32'h0000_0001, 12'h342, 10, 0, 0);
        add_row(csr_pkg::CSR_RW, 0, 5'd1,  32'hffff_ffff, 12'h300, 11, 0, 0);  // only 0x88 sticks
        add_row(csr_pkg::CSR_RS, 0, 5'd0,  32'hffff_ffff, 12'h300, 12, 0, 0);  // x0 source
        add_row(csr_pkg::CSR_RW, 0, 5'd4,  32'h1234_5677, 12'h305, 13, 0, 0);
        add_row(csr_pkg::CSR_RW, 1, 5'h1f, 32'h0,         12'h341, 14, 0, 0);
        add_row(csr_pkg::CSR_RW, 0, 5'd2,  32'hcafe_f00d, 12'h7c0, 15, 0, 0);  // unknown csr
        add_row(csr_pkg::CSR_RC, 0, 5'd0,  32'hffff_ffff, 12'h340, 0,  0, 0);  // rd x0
        add_row(csr_pkg::CSR_RS, 1, 5'd1,  32'h0,         12'h340, 16, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd2,  32'h0,         12'h340, 17, 0, 1);
        add_row(csr_pkg::CSR_RC, 1, 5'd1,  32'h0,         12'h340, 18, 0, 1);
        add_row(csr_pkg::CSR_RW, 0, 5'd5,  32'ha5a5_a5a5, 12'h340, 0,  0, 1);
        add_row(csr_pkg::CSR_RW, 0, 5'd6,  32'h9999_9999, 12'h340, 19, 1, 1);  // flushed
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h340, 20, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h305, 21, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h341, 22, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h7c0, 23, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h300, 24, 0, 1);
        add_row(csr_pkg::CSR_RS, 1, 5'd0,  32'h0,         12'h342, 25, 0, 1);
        limit = 20 * rows.size() + 50;
        repeat (3) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        foreach (rows[i]) begin
            r  = rows[i];
            f3 = (r.op == csr_pkg::CSR_RW) ? 2'b01 : (r.op == csr_pkg::CSR_RS) ? 2'b10 : 2'b11;
            instr_i       = {r.addr, r.src, r.imm, f3, r.rd, 7'h73};  // SYSTEM opcode
            rs1_data_i    = r.rs1;
            commit_id_i   = cid;
            int_assert_i  = r.intr;
            instr_valid_i = 1'b1;
            accepted      = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = instr_ready_o;  // transfers at the coming edge
                if (accepted)
                    predict(r, cid);
                step_cycle(r.rnd);
            end
            cid++;
        end
        instr_valid_i = 1'b0;
        int_assert_i  = 1'b0;
        while (exp_q.size() != 0)
            step_cycle(1'b0);
        repeat (4) step_cycle(1'b0);  // a stray write-back would still hit the monitor
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== csr_sva.sv ====
// csr_sva: handshake and write-back assertions, bound into csr_top
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_sva (
    input logic                    clk,
    input logic                    rst_n_i,
    input logic                    instr_valid_i,
    input logic                    instr_ready_o,
    input logic [31:0]             instr_i,
    input logic                    wb_valid_o,
    input logic                    wb_ready_i,
    input logic                    rd_we_o,
    input logic [`REG_ADDR_W-1:0]  rd_addr_o,
    input logic [`XLEN-1:0]        rd_data_o,
    input logic [`COMMIT_ID_W-1:0] commit_id_o
);

    // held result must not move until taken
    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(rd_we_o) && $stable(rd_addr_o)
            && $stable(rd_data_o) && $stable(commit_id_o))
        else $error("write-back outputs changed under back-pressure");

    a_instr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        instr_valid_i && !instr_ready_o |=> $stable(instr_i))
        else $error("instr_i changed while waiting for ready");

    a_x0_no_we: assert property (@(posedge clk) disable iff (!rst_n_i)
        rd_we_o |-> rd_addr_o != '0)
        else $error("rd_we_o high with rd x0");

    // empty pipe right out of reset
    a_reset_idle: assert property (@(posedge clk) $rose(rst_n_i) |-> !wb_valid_o)
        else $error("wb_valid_o high in the first cycle after reset");

endmodule

bind csr_top csr_sva csr_sva_inst (
    .clk(clk), .rst_n_i(rst_n_i), .instr_valid_i(instr_valid_i),
    .instr_ready_o(instr_ready_o), .instr_i(instr_i), .wb_valid_o(wb_valid_o),
    .wb_ready_i(wb_ready_i), .rd_we_o(rd_we_o), .rd_addr_o(rd_addr_o),
    .rd_data_o(rd_data_o), .commit_id_o(commit_id_o)
);

// ==== verilog.f ====
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_exec_unit.sv
csr_regfile.sv
csr_top.sv
csr_tb.sv
csr_sva.sv
